//--- common/fm_params.svh
// fm slot engine constants for widths, slot counts, latencies and register ranges
`ifndef FM_PARAMS_SVH
`define FM_PARAMS_SVH

`define FM_NUM_SLOTS     18          // operator slots in the bank
`define FM_NUM_CHANNELS  9           // two-operator channels
`define FM_SLOT_CYCLES   2           // clocks per slot
`define FM_OP_LATENCY    4           // issue to valid output
`define FM_MOD_DELAY     2           // router delay, latency + delay = 3 slot periods

`define FM_PHASE_WIDTH   20
`define FM_OUT_WIDTH     13

// register range bases
`define FM_REG_MULT      8'h20
`define FM_REG_TL        8'h40
`define FM_REG_FNUM_LO   8'hA0
`define FM_REG_KON_BLOCK 8'hB0
`define FM_REG_CONN      8'hC0

// entries per range, slot ranges include the hole offsets
`define FM_SLOT_SPAN     22
`define FM_CHAN_SPAN     9

`endif

//--- common/fm_pkg.sv
// shared types for the fm slot engine: register writes, slot parameters and output stream
`include "fm_params.svh"

package fm_pkg;

    typedef logic [$clog2(`FM_NUM_SLOTS)-1:0] slot_num_t;

    // host register write, one cycle strobe
    typedef struct packed {
        logic       valid;
        logic [7:0] address;
        logic [7:0] data;
    } reg_wr_t;

    // per-slot operator parameters
    typedef struct packed {
        logic [3:0] mult;    // frequency multiplier
        logic [5:0] tl;      // total level, upper 3 bits give the shift
    } slot_params_t;

    // per-channel parameters
    typedef struct packed {
        logic [9:0] fnum;    // f-number
        logic [2:0] block;   // octave
        logic       kon;     // key on
        logic       cnt;     // 1 = additive, 0 = fm
    } chan_params_t;

    // tagged operator output
    typedef struct packed {
        logic                            valid;
        slot_num_t                       slot;
        logic signed [`FM_OUT_WIDTH-1:0] value;
    } op_out_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_HOLD
    } seq_state_e;

    typedef enum logic {
        ROLE_MODULATOR,
        ROLE_CARRIER
    } slot_role_e;

endpackage

//--- slot_regs/slot_reg_file.sv
// per-slot multiplier and total level registers with write decode and slot offset mapping
`include "fm_params.svh"

module slot_reg_file
    import fm_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  reg_wr_t      reg_wr,
    input  slot_num_t    issue_slot,
    output slot_params_t slot_params
);
    localparam int OFF_W = $clog2(`FM_SLOT_SPAN);

    logic [$bits(slot_params.mult)-1:0] mult_mem [`FM_SLOT_SPAN];
    logic [$bits(slot_params.tl)-1:0]   tl_mem   [`FM_SLOT_SPAN];

    logic             mult_hit;
    logic             tl_hit;
    logic [OFF_W-1:0] wr_off;
    logic [OFF_W-1:0] rd_off;

    always_comb begin
        mult_hit = reg_wr.valid && reg_wr.address >= `FM_REG_MULT
                   && reg_wr.address < `FM_REG_MULT + `FM_SLOT_SPAN;
        tl_hit   = reg_wr.valid && reg_wr.address >= `FM_REG_TL
                   && reg_wr.address < `FM_REG_TL + `FM_SLOT_SPAN;
        wr_off   = reg_wr.address[OFF_W-1:0];   // bases are 32-aligned
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FM_SLOT_SPAN; i++) begin
                mult_mem[i] <= '0;
            end
        end else if (mult_hit) begin
            mult_mem[wr_off] <= reg_wr.data[$bits(slot_params.mult)-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FM_SLOT_SPAN; i++) begin
                tl_mem[i] <= '0;
            end
        end else if (tl_hit) begin
            tl_mem[wr_off] <= reg_wr.data[$bits(slot_params.tl)-1:0];
        end
    end

    // slots sit in three groups of six, offsets 6-7 and 14-15 are holes
    always_comb begin
        if (issue_slot < 5'd6) begin
            rd_off = OFF_W'(issue_slot);
        end else if (issue_slot < 5'd12) begin
            rd_off = OFF_W'(issue_slot + 5'd2);
        end else begin
            rd_off = OFF_W'(issue_slot + 5'd4);
        end
    end

    always_comb begin
        slot_params.mult = mult_mem[rd_off];
        slot_params.tl   = tl_mem[rd_off];
    end

endmodule

//--- slot_regs/channel_reg_file.sv
// per-channel f-number, block, key-on and connection registers with slot to channel mapping
`include "fm_params.svh"

module channel_reg_file
    import fm_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  reg_wr_t      reg_wr,
    input  slot_num_t    issue_slot,
    output chan_params_t chan_params
);
    localparam int CH_W = $clog2(`FM_NUM_CHANNELS);

    logic [7:0] fnum_lo_mem   [`FM_NUM_CHANNELS];
    logic [5:0] kon_block_mem [`FM_NUM_CHANNELS];  // {kon, block, fnum[9:8]}
    logic       cnt_mem       [`FM_NUM_CHANNELS];

    logic            lo_hit;
    logic            kb_hit;
    logic            conn_hit;
    logic [CH_W-1:0] wr_ch;
    logic [CH_W-1:0] rd_ch;
    slot_num_t       pos;
    slot_num_t       grp_base;

    always_comb begin
        lo_hit   = reg_wr.valid && reg_wr.address >= `FM_REG_FNUM_LO
                   && reg_wr.address < `FM_REG_FNUM_LO + `FM_CHAN_SPAN;
        kb_hit   = reg_wr.valid && reg_wr.address >= `FM_REG_KON_BLOCK
                   && reg_wr.address < `FM_REG_KON_BLOCK + `FM_CHAN_SPAN;
        conn_hit = reg_wr.valid && reg_wr.address >= `FM_REG_CONN
                   && reg_wr.address < `FM_REG_CONN + `FM_CHAN_SPAN;
        wr_ch    = reg_wr.address[CH_W-1:0];   // low nibble is the channel
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FM_NUM_CHANNELS; i++) begin
                fnum_lo_mem[i]   <= '0;
                kon_block_mem[i] <= '0;
                cnt_mem[i]       <= 1'b0;
            end
        end else begin
            if (lo_hit)
                fnum_lo_mem[wr_ch] <= reg_wr.data;
            if (kb_hit)
                kon_block_mem[wr_ch] <= reg_wr.data[5:0];
            if (conn_hit)
                cnt_mem[wr_ch] <= reg_wr.data[0];
        end
    end

    // channel = (slot mod 3) + 3 * (slot div 6)
    always_comb begin
        if (issue_slot < 5'd6) begin
            pos      = issue_slot;
            grp_base = 5'd0;
        end else if (issue_slot < 5'd12) begin
            pos      = issue_slot - 5'd6;
            grp_base = 5'd3;
        end else begin
            pos      = issue_slot - 5'd12;
            grp_base = 5'd6;
        end
        rd_ch = CH_W'((pos < 5'd3 ? pos : pos - 5'd3) + grp_base);
    end

    always_comb begin
        chan_params.fnum  = {kon_block_mem[rd_ch][1:0], fnum_lo_mem[rd_ch]};
        chan_params.block = kon_block_mem[rd_ch][4:2];
        chan_params.kon   = kon_block_mem[rd_ch][5];
        chan_params.cnt   = cnt_mem[rd_ch];
    end

endmodule

//--- verilog/slot_sequencer.sv
// slot sequencer, walks the 18 operator slots two cycles each after a sample tick
`include "fm_params.svh"

module slot_sequencer
    import fm_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      sample_clk_en,
    output logic      op_issue,
    output slot_num_t issue_slot
);
    seq_state_e state;
    seq_state_e state_nxt;
    slot_num_t  slot_cnt;
    logic       last_slot;

    assign last_slot = slot_cnt == slot_num_t'(`FM_NUM_SLOTS - 1);

    always_comb begin
        case (state)
            SEQ_IDLE:  state_nxt = sample_clk_en ? SEQ_ISSUE : SEQ_IDLE;
            SEQ_ISSUE: state_nxt = SEQ_HOLD;
            SEQ_HOLD:  state_nxt = last_slot ? SEQ_IDLE : SEQ_ISSUE;
            default:   state_nxt = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= SEQ_IDLE;
            slot_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == SEQ_IDLE)
                slot_cnt <= '0;                  // ready for the next pass
            else if (state == SEQ_HOLD && !last_slot)
                slot_cnt <= slot_cnt + 1'b1;
        end
    end

    // ticks seen outside idle are dropped by the fsm
    assign op_issue   = state == SEQ_ISSUE;
    assign issue_slot = slot_cnt;

endmodule

//--- verilog/fm_operator.sv
// four-stage fm operator with per-slot phase accumulator, modulation add and level shift
`include "fm_params.svh"

module fm_operator
    import fm_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            op_issue,
    input  slot_num_t                       issue_slot,
    input  slot_params_t                    slot_params,
    input  chan_params_t                    chan_params,
    input  logic signed [`FM_OUT_WIDTH-1:0] modulation,
    output op_out_t                         op_out
);
    localparam int PW = `FM_PHASE_WIDTH;
    localparam int OW = `FM_OUT_WIDTH;
    localparam int LAT = `FM_OP_LATENCY;

    logic [PW-1:0] phase_mem [`FM_NUM_SLOTS];

    logic [LAT-1:0] vld_sr;                // valid per stage with s1 at index 0
    slot_num_t      slot_sr [LAT];

    // stage 1 captured on issue
    slot_params_t        sp_s1;
    chan_params_t        cp_s1;
    logic signed [OW-1:0] mod_s1;
    // stage 2
    logic [PW-1:0]        inc_s2;
    logic [PW-1:0]        old_s2;
    logic                 kon_s2;
    logic [$bits(slot_params.tl)-1:0] tl_s2;
    logic signed [OW-1:0] mod_s2;
    // stage 3
    logic [PW-1:0]        phase_s3;
    logic                 kon_s3;
    logic [$bits(slot_params.tl)-1:0] tl_s3;
    logic signed [OW-1:0] mod_s3;
    // stage 4
    logic signed [OW-1:0] out_s4;

    logic [PW-1:0]        inc_nxt;
    logic [PW-1:0]        phase_nxt;
    logic signed [OW-1:0] sum_nxt;
    logic signed [OW-1:0] lvl_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            vld_sr <= '0;
        else
            vld_sr <= {vld_sr[LAT-2:0], op_issue};
    end

    always_ff @(posedge clk) begin
        slot_sr[0] <= issue_slot;
        for (int i = 1; i < LAT; i++) begin
            slot_sr[i] <= slot_sr[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (op_issue) begin
            sp_s1  <= slot_params;
            cp_s1  <= chan_params;
            mod_s1 <= modulation;
        end
    end

    // (fnum << block) * mult wraps with the phase
    assign inc_nxt   = (PW'(cp_s1.fnum) << cp_s1.block) * PW'(sp_s1.mult);
    assign phase_nxt = kon_s2 ? old_s2 + inc_s2 : '0;   // key off restarts phase
    assign sum_nxt   = $signed(phase_s3[PW-1 -: OW]) + mod_s3;
    assign lvl_nxt   = sum_nxt >>> tl_s3[5:3];           // sign kept through the shift

    always_ff @(posedge clk) begin
        inc_s2   <= inc_nxt;
        old_s2   <= phase_mem[slot_sr[0]];
        kon_s2   <= cp_s1.kon;
        tl_s2    <= sp_s1.tl;
        mod_s2   <= mod_s1;
        phase_s3 <= phase_nxt;
        kon_s3   <= kon_s2;
        tl_s3    <= tl_s2;
        mod_s3   <= mod_s2;
        out_s4   <= kon_s3 ? lvl_nxt : '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FM_NUM_SLOTS; i++) begin
                phase_mem[i] <= '0;
            end
        end else if (vld_sr[1]) begin
            phase_mem[slot_sr[1]] <= phase_nxt;   // write back from stage 2
        end
    end

    always_comb begin
        op_out.valid = vld_sr[LAT-1];
        op_out.slot  = slot_sr[LAT-1];
        op_out.value = out_s4;
    end

endmodule

//--- verilog/mod_router.sv
// modulation router, delays modulator output to its carrier's issue and flags end of pass
`include "fm_params.svh"

module mod_router
    import fm_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  op_out_t                         op_out,
    input  chan_params_t                    chan_params,
    input  slot_num_t                       issue_slot,
    output logic signed [`FM_OUT_WIDTH-1:0] modulation,
    output logic                            done_pulse   // one cycle after slot 17 output
);
    localparam int D = `FM_MOD_DELAY;

    logic [D-1:0]                    dly_valid;
    logic signed [`FM_OUT_WIDTH-1:0] dly_value [D];
    slot_role_e                      role;
    slot_num_t                       pos;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dly_valid  <= '0;
            done_pulse <= 1'b0;
        end else begin
            for (int i = D - 1; i > 0; i--) begin
                dly_valid[i] <= dly_valid[i-1];
            end
            dly_valid[0] <= op_out.valid;
            done_pulse   <= op_out.valid && op_out.slot == slot_num_t'(`FM_NUM_SLOTS - 1);
        end
    end

    always_ff @(posedge clk) begin
        dly_value[0] <= op_out.value;
        for (int i = 1; i < D; i++) begin
            dly_value[i] <= dly_value[i-1];
        end
    end

    // first three slots of each group of six are modulators
    always_comb begin
        if (issue_slot < 5'd6)
            pos = issue_slot;
        else if (issue_slot < 5'd12)
            pos = issue_slot - 5'd6;
        else
            pos = issue_slot - 5'd12;
        role = pos < 5'd3 ? ROLE_MODULATOR : ROLE_CARRIER;
    end

    // delayed slot s output lands on the issue of slot s+3
    assign modulation = (role == ROLE_CARRIER && !chan_params.cnt && dly_valid[D-1])
                        ? dly_value[D-1] : '0;

endmodule

//--- verilog/fm_slot_engine.sv
// fm slot engine top, register files, slot sequencer, operator and modulation router
`include "fm_params.svh"

module fm_slot_engine
    import fm_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    sample_clk_en,
    input  reg_wr_t reg_wr,
    output op_out_t op_out,
    output logic    done_pulse
);
    logic                            op_issue;
    slot_num_t                       issue_slot;
    slot_params_t                    slot_params;
    chan_params_t                    chan_params;
    logic signed [`FM_OUT_WIDTH-1:0] modulation;

    slot_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .op_issue      (op_issue),
        .issue_slot    (issue_slot)
    );

    slot_reg_file u_slot_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wr      (reg_wr),
        .issue_slot  (issue_slot),
        .slot_params (slot_params)
    );

    channel_reg_file u_chan_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wr      (reg_wr),
        .issue_slot  (issue_slot),
        .chan_params (chan_params)
    );

    fm_operator u_op (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_issue    (op_issue),
        .issue_slot  (issue_slot),
        .slot_params (slot_params),
        .chan_params (chan_params),
        .modulation  (modulation),
        .op_out      (op_out)
    );

    mod_router u_router (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_out      (op_out),
        .chan_params (chan_params),
        .issue_slot  (issue_slot),
        .modulation  (modulation),
        .done_pulse  (done_pulse)
    );

endmodule

//--- sim/fm_slot_engine_tb_tasks.svh
// directed tests, register write helper and pass collection with timeout for the slot engine
`ifndef FM_SLOT_ENGINE_TB_TASKS_SVH
`define FM_SLOT_ENGINE_TB_TASKS_SVH

    task automatic check_equal(input string name, input string what,
                               input int expected, input int actual);
        assert (expected == actual) else begin
            errors++;
            $display("Mismatch %s %s: expected %0d actual %0d", name, what, expected, actual);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        reg_wr <= '{valid: 1'b1, address: addr, data: data};
        @(posedge clk);
        reg_wr <= '0;
        model_write(addr, data);
    endtask

    // one tick and the whole pass collected
    // mid_tick pulses a second tick while busy
    task automatic run_pass(input string name, input bit mid_tick);
        int cyc;
        int n_out;
        int n_done;
        int done_cyc;
        model_pass();
        cyc      = 0;
        n_out    = 0;
        n_done   = 0;
        done_cyc = -1;
        @(posedge clk);
        sample_clk_en <= 1'b1;
        while (done_cyc < 0 || cyc < done_cyc + 4) begin
            @(negedge clk);
            if (op_out.valid) begin
                check_equal(name, "output slot", n_out, int'(op_out.slot));
                check_equal(name, "output cycle", FIRST_OUT + `FM_SLOT_CYCLES * n_out, cyc);
                if (n_out < `FM_NUM_SLOTS)
                    check_equal(name, $sformatf("slot %0d value", n_out),
                                int'(exp_val[n_out]), int'($signed(op_out.value)));
                n_out++;
            end
            if (done_pulse) begin
                check_equal(name, "done cycle",
                            FIRST_OUT + `FM_SLOT_CYCLES * (`FM_NUM_SLOTS - 1) + 1, cyc);
                n_done++;
                done_cyc = cyc;
            end
            @(posedge clk);
            cyc++;
            sample_clk_en <= mid_tick && cyc == 12;   // lands in the middle of the pass
            if (cyc > PASS_TIMEOUT) begin
                timeouts++;
                $display("%s: timed out waiting for the end-of-sample done pulse", name);
                break;
            end
        end
        check_equal(name, "output count", `FM_NUM_SLOTS, n_out);
        check_equal(name, "done pulse count", 1, n_done);
    endtask

    // random f-number, block, mult and tl for one keyed-on channel
    task automatic setup_channel(input int ch, input bit cnt);
        int mod_slot;
        mod_slot = (ch % 3) + 6 * (ch / 3);
        write_reg(8'(`FM_REG_FNUM_LO + ch), 8'($urandom));
        write_reg(8'(`FM_REG_KON_BLOCK + ch), 8'(32'h20 | ($urandom % 32)));
        write_reg(8'(`FM_REG_CONN + ch), {7'd0, cnt});
        write_reg(8'(`FM_REG_MULT + slot_offset(mod_slot)), 8'($urandom % 15 + 1));
        write_reg(8'(`FM_REG_MULT + slot_offset(mod_slot + 3)), 8'($urandom % 15 + 1));
        write_reg(8'(`FM_REG_TL + slot_offset(mod_slot)), 8'($urandom % 64));
        write_reg(8'(`FM_REG_TL + slot_offset(mod_slot + 3)), 8'($urandom % 64));
    endtask

    task automatic test_reset_zero();
        run_pass("reset_zero", 1'b0);
    endtask

    task automatic test_additive();
        setup_channel(0, 1'b1);
        repeat (4) run_pass("additive", 1'b0);
    endtask

    // slot 6 issues right after carrier slot 3 and must stay unmodulated
    task automatic test_fm();
        setup_channel(0, 1'b0);
        setup_channel(3, 1'b0);
        setup_channel(4, 1'b0);
        repeat (4) run_pass("fm", 1'b0);
    endtask

    // offset 8 reaches slot 6 and hole offsets reach no slot
    task automatic test_mapping();
        int holes [4] = '{6, 7, 14, 15};
        write_reg(8'(`FM_REG_MULT + 8), 8'($urandom % 15 + 1));
        write_reg(8'(`FM_REG_TL + 8), 8'($urandom % 16));
        write_reg(8'(`FM_REG_FNUM_LO + 3), 8'($urandom));
        write_reg(8'(`FM_REG_KON_BLOCK + 3), 8'(32'h20 | ($urandom % 32)));
        foreach (holes[i]) begin
            write_reg(8'(`FM_REG_MULT + holes[i]), 8'($urandom));
            write_reg(8'(`FM_REG_TL + holes[i]), 8'($urandom));
        end
        repeat (3) run_pass("mapping", 1'b0);
    endtask

    task automatic test_key_off();
        write_reg(8'(`FM_REG_KON_BLOCK), {3'b000, m_kb[0][4:0]});
        run_pass("key_off", 1'b1);
        write_reg(8'(`FM_REG_KON_BLOCK), {3'b001, m_kb[0][4:0]});
        run_pass("key_restart", 1'b1);
        run_pass("key_restart", 1'b0);
    endtask

`endif

//--- sim/fm_slot_engine_tb.sv
// testbench for the fm slot engine with a reference operator model and directed tests
`include "fm_params.svh"

module fm_slot_engine_tb
    import fm_pkg::*;
();
    localparam int PASS_TIMEOUT = 80;                    // cycles allowed for one pass
    localparam int FIRST_OUT    = 1 + `FM_OP_LATENCY;     // tick cycle to slot 0 output

    logic    clk = 1'b0;
    logic    rst_n;
    logic    sample_clk_en;
    reg_wr_t reg_wr;
    op_out_t op_out;
    logic    done_pulse;

    int errors;
    int timeouts;

    // reference register state and per-slot phase
    logic [3:0]         m_mult    [`FM_SLOT_SPAN];
    logic [5:0]         m_tl      [`FM_SLOT_SPAN];
    logic [7:0]         m_fnum_lo [`FM_NUM_CHANNELS];
    logic [5:0]         m_kb      [`FM_NUM_CHANNELS];   // {kon, block, fnum hi}
    logic               m_cnt     [`FM_NUM_CHANNELS];
    logic [19:0]        m_phase   [`FM_NUM_SLOTS];
    logic signed [12:0] exp_val   [`FM_NUM_SLOTS];      // expected outputs of the next pass

    fm_slot_engine u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .reg_wr        (reg_wr),
        .op_out        (op_out),
        .done_pulse    (done_pulse)
    );

    always #2 clk = ~clk;

    function automatic int slot_offset(input int s);
        if (s < 6)
            return s;
        else if (s < 12)
            return s + 2;
        return s + 4;
    endfunction

    function automatic int slot_channel(input int s);
        return (s % 3) + 3 * (s / 6);
    endfunction

    function automatic bit is_carrier(input int s);
        return (s % 6) >= 3;
    endfunction

    task automatic model_clear();
        for (int i = 0; i < `FM_SLOT_SPAN; i++) begin
            m_mult[i] = '0;
            m_tl[i]   = '0;
        end
        for (int i = 0; i < `FM_NUM_CHANNELS; i++) begin
            m_fnum_lo[i] = '0;
            m_kb[i]      = '0;
            m_cnt[i]     = 1'b0;
        end
        for (int i = 0; i < `FM_NUM_SLOTS; i++) begin
            m_phase[i] = '0;
            exp_val[i] = '0;
        end
    endtask

    // register decode as the host sees it
    task automatic model_write(input logic [7:0] addr, input logic [7:0] data);
        int a;
        a = int'(addr);
        if (a >= `FM_REG_MULT && a < `FM_REG_MULT + `FM_SLOT_SPAN)
            m_mult[a - `FM_REG_MULT] = data[3:0];
        if (a >= `FM_REG_TL && a < `FM_REG_TL + `FM_SLOT_SPAN)
            m_tl[a - `FM_REG_TL] = data[5:0];
        if (a >= `FM_REG_FNUM_LO && a < `FM_REG_FNUM_LO + `FM_CHAN_SPAN)
            m_fnum_lo[a - `FM_REG_FNUM_LO] = data;
        if (a >= `FM_REG_KON_BLOCK && a < `FM_REG_KON_BLOCK + `FM_CHAN_SPAN)
            m_kb[a - `FM_REG_KON_BLOCK] = data[5:0];
        if (a >= `FM_REG_CONN && a < `FM_REG_CONN + `FM_CHAN_SPAN)
            m_cnt[a - `FM_REG_CONN] = data[0];
    endtask

    // one sample pass, new phase then top bits plus modulation then level shift
    task automatic model_pass();
        int                 ch;
        logic [31:0]        inc;
        logic [9:0]         fnum;
        logic signed [12:0] modv;
        logic signed [12:0] sum;
        for (int s = 0; s < `FM_NUM_SLOTS; s++) begin
            ch   = slot_channel(s);
            fnum = {m_kb[ch][1:0], m_fnum_lo[ch]};
            inc  = (32'(fnum) << m_kb[ch][4:2]) * 32'(m_mult[slot_offset(s)]);
            modv = (is_carrier(s) && !m_cnt[ch]) ? exp_val[s - 3] : 13'sd0;
            if (m_kb[ch][5]) begin
                m_phase[s] = m_phase[s] + inc[19:0];       // wraps at 20 bits
                sum        = $signed(m_phase[s][19:7]) + modv;
                exp_val[s] = sum >>> m_tl[slot_offset(s)][5:3];
            end else begin
                m_phase[s] = '0;
                exp_val[s] = '0;
            end
        end
    endtask

    `include "fm_slot_engine_tb_tasks.svh"

    initial begin
        errors        = 0;
        timeouts      = 0;
        rst_n         <= 1'b0;
        sample_clk_en <= 1'b0;
        reg_wr        <= '0;
        void'($urandom(82146));
        model_clear();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_reset_zero();
        test_additive();
        test_fm();
        test_mapping();
        test_key_off();
        $display("closing: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- fm_slot_engine.f
+incdir+common
+incdir+sim
common/fm_pkg.sv
slot_regs/slot_reg_file.sv
slot_regs/channel_reg_file.sv
verilog/slot_sequencer.sv
verilog/fm_operator.sv
verilog/mod_router.sv
verilog/fm_slot_engine.sv
sim/fm_slot_engine_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= fm_slot_engine_tb
FILELIST  ?= fm_slot_engine.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
